//--- flist.f
logic/clint_pkg.sv
logic/clint_bus_decoder.sv
logic/clint_timer_regs.sv
logic/clint_irq_compare.sv
logic/clint_top.sv
verif/clint_sva.sv
verif/clint_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the CLINT testbench with Verilator, run it and check the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    --top-module clint_tb \
    -f flist.f \
    -o clint_sim

./obj_dir/clint_sim > sim.log 2>&1
cat sim.log

if grep -qx "Finished with no errors" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

//--- verif/clint_tb.sv
// ==========================================================
// CLINT testbench
// Directed tests over the register bus: reset state, msip,
// mtimecmp byte writes, timer interrupt and error accesses
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

module clint_tb;

    logic                             clk;
    logic                             rst_n;
    logic                             mtime_increment;
    clint_pkg::clint_req_t            req;
    clint_pkg::clint_rsp_t            rsp;
    logic [clint_pkg::hart_count-1:0] hart_swi;
    logic [clint_pkg::hart_count-1:0] hart_timeri;

    int          error_count;
    int          test_count;
    logic [31:0] lcg_state;
    logic [63:0] cmp_model [clint_pkg::hart_count];
    logic [63:0] time_model;

    clint_top i_clint_top (
        .clk             (clk),
        .rst_n           (rst_n),
        .req             (req),
        .rsp             (rsp),
        .mtime_increment (mtime_increment),
        .hart_swi        (hart_swi),
        .hart_timeri     (hart_timeri)
    );

    bind clint_top clint_sva i_clint_sva (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .rsp         (rsp),
        .hart_swi    (hart_swi),
        .hart_timeri (hart_timeri)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [15:0] msip_addr(input int hart);
        return clint_pkg::msip_base + 16'(hart * 4);
    endfunction

    function automatic logic [15:0] cmp_addr(input int hart, input logic high);
        return clint_pkg::mtimecmp_base + 16'(hart * 8) + (high ? 16'd4 : 16'd0);
    endfunction

    // Old word with the strobed byte lanes taken from the new data
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] data,
                                                input logic [3:0]  strb);
        logic [31:0] result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) result[b*8 +: 8] = data[b*8 +: 8];
        end
        return result;
    endfunction

    task automatic check_value(input string signal, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            error_count++;
            $display("** Error: %s expected 0x%08h, got 0x%08h", signal, expected, actual);
        end
    endtask

    // One request on a falling edge, then wait for its response
    task automatic bus_access(input logic write, input logic [15:0] addr,
                              input logic [31:0] wdata, input logic [3:0] wstrb,
                              output logic [31:0] rdata, output logic error);
        bit got;
        @(negedge clk);
        req.valid = 1'b1;
        req.write = write;
        req.addr  = addr;
        req.wdata = wdata;
        req.wstrb = wstrb;
        @(negedge clk);
        req   = '0;
        got   = 1'b0;
        rdata = 32'd0;
        error = 1'b1;
        for (int n = 0; n < 10 && !got; n++) begin
            if (rsp.valid) begin
                got   = 1'b1;
                rdata = rsp.rdata;
                error = rsp.error;
            end else begin
                @(negedge clk);
            end
        end
        if (!got) begin
            error_count++;
            $display("No response to the access at 0x%04h within 10 cycles", addr);
        end
    endtask

    task automatic read_expect(input string name, input logic [15:0] addr,
                               input logic [31:0] expected, input logic expected_error);
        logic [31:0] rdata;
        logic        error;
        bus_access(1'b0, addr, 32'd0, 4'h0, rdata, error);
        check_value($sformatf("rsp.rdata (%s)", name), expected, rdata);
        check_value($sformatf("rsp.error (%s)", name), 32'(expected_error), 32'(error));
    endtask

    // Response data of a write is the value before the write
    task automatic write_expect(input string name, input logic [15:0] addr,
                                input logic [31:0] data, input logic [3:0] strb,
                                input logic [31:0] old_value, input logic expected_error);
        logic [31:0] rdata;
        logic        error;
        bus_access(1'b1, addr, data, strb, rdata, error);
        check_value($sformatf("rsp.rdata (%s)", name), old_value, rdata);
        check_value($sformatf("rsp.error (%s)", name), 32'(expected_error), 32'(error));
    endtask

    task automatic pulse_timer(input int count);
        for (int i = 0; i < count; i++) begin
            @(negedge clk);
            mtime_increment = 1'b1;
            @(negedge clk);
            mtime_increment = 1'b0;
        end
        time_model = time_model + 64'(count);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("Test %s: passed", name);
        end else begin
            $display("Test %s: failed, %0d errors", name, error_count - errors_before);
        end
    endtask

    task automatic test_reset_state();
        int errors_before;
        errors_before = error_count;
        for (int h = 0; h < clint_pkg::hart_count; h++) begin
            read_expect("msip", msip_addr(h), 32'd0, 1'b0);
            read_expect("mtimecmp low", cmp_addr(h, 1'b0), 32'hFFFF_FFFF, 1'b0);
            read_expect("mtimecmp high", cmp_addr(h, 1'b1), 32'hFFFF_FFFF, 1'b0);
        end
        read_expect("mtime low", clint_pkg::mtime_addr, 32'd0, 1'b0);
        read_expect("mtime high", clint_pkg::mtime_addr + 16'd4, 32'd0, 1'b0);
        check_value("hart_swi", 32'd0, 32'(hart_swi));
        check_value("hart_timeri", 32'd0, 32'(hart_timeri));
        finish_test("reset state", errors_before);
    endtask

    task automatic test_software_irq();
        int         errors_before;
        logic [3:0] expected;
        errors_before = error_count;
        for (int h = 0; h < clint_pkg::hart_count; h++) begin
            expected = 4'(1 << h);
            write_expect("msip set", msip_addr(h), 32'd1, 4'h1, 32'd0, 1'b0);
            check_value("hart_swi", 32'(expected), 32'(hart_swi));
            read_expect("msip", msip_addr(h), 32'd1, 1'b0);
            // Lane 0 disabled, so the bit must survive
            write_expect("msip masked", msip_addr(h), 32'd0, 4'hE, 32'd1, 1'b0);
            check_value("hart_swi", 32'(expected), 32'(hart_swi));
            write_expect("msip clear", msip_addr(h), 32'd0, 4'h1, 32'd1, 1'b0);
            check_value("hart_swi", 32'd0, 32'(hart_swi));
            read_expect("msip", msip_addr(h), 32'd0, 1'b0);
        end
        finish_test("software interrupts", errors_before);
    endtask

    task automatic test_compare_regs();
        int          errors_before;
        logic [31:0] data;
        logic [3:0]  strb;
        logic [31:0] old_word;
        logic [31:0] new_word;
        errors_before = error_count;
        for (int h = 0; h < clint_pkg::hart_count; h++) begin
            for (int half = 0; half < 2; half++) begin
                lcg_state = lcg_next(lcg_state);
                data      = lcg_state;
                lcg_state = lcg_next(lcg_state);
                strb      = lcg_state[19:16];
                old_word  = cmp_model[h][half*32 +: 32];
                new_word  = merge_bytes(old_word, data, strb);
                write_expect("mtimecmp write", cmp_addr(h, half[0]), data, strb, old_word, 1'b0);
                cmp_model[h][half*32 +: 32] = new_word;
                read_expect("mtimecmp", cmp_addr(h, half[0]), new_word, 1'b0);
            end
        end
        // Back to all ones so no timer interrupt fires later
        for (int h = 0; h < clint_pkg::hart_count; h++) begin
            for (int half = 0; half < 2; half++) begin
                old_word = cmp_model[h][half*32 +: 32];
                write_expect("mtimecmp park", cmp_addr(h, half[0]), 32'hFFFF_FFFF, 4'hF,
                             old_word, 1'b0);
            end
            cmp_model[h] = clint_pkg::mtimecmp_reset;
        end
        finish_test("compare registers", errors_before);
    endtask

    task automatic test_timer_irq();
        int          errors_before;
        int          pulses;
        int          target;
        logic [63:0] cmp_value;
        bit          risen;
        errors_before = error_count;
        lcg_state = lcg_next(lcg_state);
        pulses    = 5 + int'(lcg_state[18:16]);
        target    = int'(lcg_state[21:20]);
        pulse_timer(pulses);
        read_expect("mtime low", clint_pkg::mtime_addr, time_model[31:0], 1'b0);
        read_expect("mtime high", clint_pkg::mtime_addr + 16'd4, time_model[63:32], 1'b0);
        // High word first, the low word then brings the compare down
        cmp_value = time_model + 64'd3;
        write_expect("mtimecmp high", cmp_addr(target, 1'b1), cmp_value[63:32], 4'hF,
                     cmp_model[target][63:32], 1'b0);
        write_expect("mtimecmp low", cmp_addr(target, 1'b0), cmp_value[31:0], 4'hF,
                     cmp_model[target][31:0], 1'b0);
        cmp_model[target] = cmp_value;
        repeat (2) @(negedge clk);
        check_value("hart_timeri", 32'd0, 32'(hart_timeri));
        pulse_timer(3);
        risen = 1'b0;
        for (int n = 0; n < 10 && !risen; n++) begin
            if (hart_timeri[target]) risen = 1'b1;
            else @(negedge clk);
        end
        if (!risen) begin
            error_count++;
            $display("Timer interrupt of hart %0d did not rise within 10 cycles", target);
        end
        check_value("hart_timeri", 32'(4'(1 << target)), 32'(hart_timeri));
        finish_test("timer interrupt", errors_before);
    endtask

    task automatic test_error_access();
        int          errors_before;
        int          got;
        logic [31:0] data_q [$];
        logic        error_q [$];
        errors_before = error_count;
        read_expect("msip hart 4", msip_addr(clint_pkg::hart_count), 32'd0, 1'b1);
        write_expect("msip hart 4", msip_addr(clint_pkg::hart_count), 32'd1, 4'hF, 32'd0, 1'b1);
        check_value("hart_swi", 32'd0, 32'(hart_swi));
        read_expect("offset 0x2000", 16'h2000, 32'd0, 1'b1);
        write_expect("offset 0x2000", 16'h2000, 32'h5A5A_0001, 4'hF, 32'd0, 1'b1);
        write_expect("unaligned mtimecmp", cmp_addr(0, 1'b0) + 16'd1, 32'd0, 4'hF, 32'd0, 1'b1);
        read_expect("mtimecmp hart 0 low", cmp_addr(0, 1'b0), cmp_model[0][31:0], 1'b0);
        read_expect("unaligned msip", msip_addr(1) + 16'd2, 32'd0, 1'b1);
        write_expect("mtime write", clint_pkg::mtime_addr, 32'd0, 4'hF, 32'd0, 1'b1);
        read_expect("mtime low", clint_pkg::mtime_addr, time_model[31:0], 1'b0);

        // Two requests in consecutive cycles, answered in order
        @(negedge clk);
        req = '{valid: 1'b1, write: 1'b0, addr: clint_pkg::mtime_addr, wdata: 32'd0, wstrb: 4'h0};
        @(negedge clk);
        req = '{valid: 1'b1, write: 1'b0, addr: 16'h2000, wdata: 32'd0, wstrb: 4'h0};
        @(negedge clk);
        req = '0;
        got = 0;
        for (int n = 0; n < 10 && got < 2; n++) begin
            if (rsp.valid) begin
                data_q.push_back(rsp.rdata);
                error_q.push_back(rsp.error);
                got++;
            end
            if (got < 2) @(negedge clk);
        end
        if (got != 2) begin
            error_count++;
            $display("Back-to-back requests got %0d responses instead of 2", got);
        end else begin
            check_value("rsp.rdata (first)", time_model[31:0], data_q[0]);
            check_value("rsp.error (first)", 32'd0, 32'(error_q[0]));
            check_value("rsp.rdata (second)", 32'd0, data_q[1]);
            check_value("rsp.error (second)", 32'd1, 32'(error_q[1]));
        end
        finish_test("error accesses", errors_before);
    endtask

    initial begin
        rst_n           = 1'b0;
        req             = '0;
        mtime_increment = 1'b0;
        error_count     = 0;
        test_count      = 0;
        lcg_state       = 32'h3193;
        time_model      = 64'd0;
        for (int h = 0; h < clint_pkg::hart_count; h++) begin
            cmp_model[h] = clint_pkg::mtimecmp_reset;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_reset_state();
        test_software_irq();
        test_compare_regs();
        test_timer_irq();
        test_error_access();

        $display("Tests run: %0d, errors: %0d", test_count, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/clint_sva.sv
// ==========================================================
// CLINT bus and reset assertions
// Bound into the top level to check response timing and the
// interrupt outputs right after reset
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

module clint_sva (
    input logic                             clk,
    input logic                             rst_n,
    input clint_pkg::clint_req_t            req,
    input clint_pkg::clint_rsp_t            rsp,
    input logic [clint_pkg::hart_count-1:0] hart_swi,
    input logic [clint_pkg::hart_count-1:0] hart_timeri
);

    // Every request is answered exactly two cycles later
    property rsp_follows_req;
        @(posedge clk) disable iff (!rst_n)
        req.valid |-> ##2 rsp.valid;
    endproperty

    // No response without a request two cycles before
    property rsp_has_req;
        @(posedge clk) disable iff (!rst_n)
        rsp.valid |-> $past(req.valid, 2);
    endproperty

    // Interrupt lines come out of reset low
    property irq_low_after_reset;
        @(posedge clk)
        $rose(rst_n) |-> (hart_swi == '0) && (hart_timeri == '0);
    endproperty

    assert property (rsp_follows_req)
        else $error("response missing two cycles after a request");
    assert property (rsp_has_req)
        else $error("response without a matching request");
    assert property (irq_low_after_reset)
        else $error("interrupt output high right after reset");

endmodule

`default_nettype wire

//--- logic/clint_top.sv
// ==========================================================
// CLINT top level
// Bus decoder feeds the timer register file, whose timer and
// compare values drive the interrupt comparator
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

module clint_top (
    input  logic                             clk,
    input  logic                             rst_n,
    input  clint_pkg::clint_req_t            req,
    output clint_pkg::clint_rsp_t            rsp,
    input  logic                             mtime_increment,
    output logic [clint_pkg::hart_count-1:0] hart_swi,
    output logic [clint_pkg::hart_count-1:0] hart_timeri
);

    clint_pkg::clint_access_t access;

    logic [63:0] mtime;
    logic [63:0] mtimecmp [clint_pkg::hart_count];

    // Request to registered access
    clint_bus_decoder i_bus_decoder (
        .clk    (clk),
        .rst_n  (rst_n),
        .req    (req),
        .access (access)
    );

    // Timer, compare registers and msip bits
    clint_timer_regs i_timer_regs (
        .clk             (clk),
        .rst_n           (rst_n),
        .access          (access),
        .mtime_increment (mtime_increment),
        .rsp             (rsp),
        .mtime           (mtime),
        .mtimecmp        (mtimecmp),
        .hart_swi        (hart_swi)
    );

    // Timer interrupt lines
    clint_irq_compare i_irq_compare (
        .clk         (clk),
        .rst_n       (rst_n),
        .mtime       (mtime),
        .mtimecmp    (mtimecmp),
        .hart_timeri (hart_timeri)
    );

endmodule

`default_nettype wire

//--- logic/clint_irq_compare.sv
// ==========================================================
// CLINT interrupt comparator
// Raises each hart's timer interrupt while mtime has reached
// that hart's compare value, one cycle behind the registers
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

module clint_irq_compare (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [63:0]                      mtime,
    input  logic [63:0]                      mtimecmp [clint_pkg::hart_count],
    output logic [clint_pkg::hart_count-1:0] hart_timeri
);

    logic [clint_pkg::hart_count-1:0] timer_reached;

    // Unsigned 64-bit compare per hart
    always_comb begin
        for (int h = 0; h < clint_pkg::hart_count; h++) begin
            timer_reached[h] = (mtime >= mtimecmp[h]);
        end
    end

    // Registered interrupt lines
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hart_timeri <= '0;
        end else begin
            hart_timeri <= timer_reached;
        end
    end

endmodule

`default_nettype wire

//--- logic/clint_timer_regs.sv
// ==========================================================
// CLINT timer register file
// Holds mtime, the per-hart mtimecmp registers and msip bits,
// applies byte-enabled writes and returns one registered
// response per access
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

module clint_timer_regs (
    input  logic                            clk,
    input  logic                            rst_n,
    input  clint_pkg::clint_access_t        access,
    input  logic                            mtime_increment,
    output clint_pkg::clint_rsp_t           rsp,
    output logic [63:0]                     mtime,
    output logic [63:0]                     mtimecmp [clint_pkg::hart_count],
    output logic [clint_pkg::hart_count-1:0] hart_swi
);

    logic        write_en;
    logic        msip_write;
    logic        mtimecmp_write;
    logic [31:0] read_data;

    // Error accesses arrive with target none, so no write slips through
    assign write_en       = access.valid && access.write;
    assign msip_write     = write_en && (access.target == clint_pkg::target_msip);
    assign mtimecmp_write = write_en && (access.target == clint_pkg::target_mtimecmp);

    // Free-running machine timer
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mtime <= 64'd0;
        end else if (mtime_increment) begin
            mtime <= mtime + 64'd1;
        end
    end

    // Compare registers, one byte lane per strobe bit
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int h = 0; h < clint_pkg::hart_count; h++) begin
                mtimecmp[h] <= clint_pkg::mtimecmp_reset;
            end
        end else if (mtimecmp_write) begin
            for (int b = 0; b < 4; b++) begin
                if (access.wstrb[b]) begin
                    mtimecmp[access.hart][access.high*32 + b*8 +: 8] <= access.wdata[b*8 +: 8];
                end
            end
        end
    end

    // Software interrupt bits live in bit 0 of each msip word
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hart_swi <= '0;
        end else if (msip_write && access.wstrb[0]) begin
            hart_swi[access.hart] <= access.wdata[0];
        end
    end

    // Read mux sees the state before this access writes
    always_comb begin
        read_data = 32'd0;
        case (access.target)
            clint_pkg::target_msip: begin
                read_data[0] = hart_swi[access.hart];
            end
            clint_pkg::target_mtimecmp: begin
                if (access.high) begin
                    read_data = mtimecmp[access.hart][63:32];
                end else begin
                    read_data = mtimecmp[access.hart][31:0];
                end
            end
            clint_pkg::target_mtime: begin
                if (access.high) begin
                    read_data = mtime[63:32];
                end else begin
                    read_data = mtime[31:0];
                end
            end
            default: begin
                read_data = 32'd0;
            end
        endcase
    end

    // Response leaves one cycle after the access, data is zero on error
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp.valid <= 1'b0;
        end else begin
            rsp.valid <= access.valid;
            rsp.error <= access.error;
            rsp.rdata <= read_data;
        end
    end

endmodule

`default_nettype wire

//--- logic/clint_bus_decoder.sv
// ==========================================================
// CLINT bus decoder
// Matches each request against the msip, mtimecmp and mtime
// regions, extracts the hart number and word half, flags
// bad accesses, and registers the result for the register file
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

module clint_bus_decoder (
    input  logic                      clk,
    input  logic                      rst_n,
    input  clint_pkg::clint_req_t     req,
    output clint_pkg::clint_access_t  access
);

    clint_pkg::clint_offset_u offset;
    clint_pkg::clint_access_t next_access;

    logic [clint_pkg::addr_width-clint_pkg::offset_width-1:0] region;

    logic msip_sel;
    logic mtimecmp_sel;
    logic mtime_sel;
    logic msip_hart_ok;
    logic mtimecmp_hart_ok;
    logic addr_hit;
    logic misaligned;

    assign offset = req.addr[clint_pkg::offset_width-1:0];
    assign region = req.addr[clint_pkg::addr_width-1:clint_pkg::offset_width];

    // Region match on the upper address bits
    assign msip_sel =
        (region == clint_pkg::msip_base[clint_pkg::addr_width-1:clint_pkg::offset_width]);
    assign mtimecmp_sel =
        (region == clint_pkg::mtimecmp_base[clint_pkg::addr_width-1:clint_pkg::offset_width]);
    // Timer covers both words at 0xBFF8 and 0xBFFC
    assign mtime_sel =
        (req.addr[clint_pkg::addr_width-1:3] == clint_pkg::mtime_addr[clint_pkg::addr_width-1:3]);

    // Full index must name an existing hart so large offsets fail too
    assign msip_hart_ok     = (offset.as_word.index < 10'(clint_pkg::hart_count));
    assign mtimecmp_hart_ok = (offset.as_dword.index < 9'(clint_pkg::hart_count));

    assign addr_hit = (msip_sel && msip_hart_ok)
                   || (mtimecmp_sel && mtimecmp_hart_ok)
                   || mtime_sel;

    assign misaligned = (offset.as_word.byte_off != 2'b00);

    always_comb begin
        next_access        = '0;
        next_access.valid  = req.valid;
        next_access.write  = req.write;
        next_access.wdata  = req.wdata;
        next_access.wstrb  = req.wstrb;
        // Address bit 2 picks the upper word of mtimecmp and mtime alike
        next_access.high   = offset.as_dword.high;
        next_access.target = clint_pkg::target_none;

        if (msip_sel) begin
            next_access.target = clint_pkg::target_msip;
            next_access.hart   = offset.as_word.index[clint_pkg::hart_id_width-1:0];
        end else if (mtimecmp_sel) begin
            next_access.target = clint_pkg::target_mtimecmp;
            next_access.hart   = offset.as_dword.index[clint_pkg::hart_id_width-1:0];
        end else if (mtime_sel) begin
            next_access.target = clint_pkg::target_mtime;
        end

        if (!addr_hit || misaligned || (mtime_sel && req.write)) begin
            next_access.error  = 1'b1;
            next_access.target = clint_pkg::target_none;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            access <= '0;
        end else begin
            access <= next_access;
        end
    end

endmodule

`default_nettype wire

//--- logic/clint_pkg.sv
// ==========================================================
// CLINT shared definitions
// Address map, hart count, bus request and response types,
// the decoded register access and the offset decode union
// ==========================================================

`default_nettype none

package clint_pkg;

    // Harts served by this interruptor
    localparam int unsigned hart_count    = 4;
    localparam int unsigned hart_id_width = 2;

    localparam int unsigned addr_width   = 16;
    // Low address bits that index inside one region
    localparam int unsigned offset_width = 12;

    // Region offsets
    localparam logic [addr_width-1:0] msip_base     = 16'h0000;
    localparam logic [addr_width-1:0] mtimecmp_base = 16'h4000;
    localparam logic [addr_width-1:0] mtime_addr    = 16'hBFF8;

    // Compare value that keeps the timer interrupt off
    localparam logic [63:0] mtimecmp_reset = 64'hFFFF_FFFF_FFFF_FFFF;

    typedef struct packed {
        logic                  valid;
        logic                  write;
        logic [addr_width-1:0] addr;
        logic [31:0]           wdata;
        logic [3:0]            wstrb;
    } clint_req_t;

    typedef struct packed {
        logic        valid;
        logic        error;
        logic [31:0] rdata;
    } clint_rsp_t;

    typedef enum logic [1:0] {
        target_none,
        target_msip,
        target_mtimecmp,
        target_mtime
    } clint_target_e;

    typedef struct packed {
        logic                     valid;
        logic                     write;
        logic                     error;
        clint_target_e            target;
        logic [hart_id_width-1:0] hart;
        logic                     high;     // upper 32 bits of a 64-bit register
        logic [31:0]              wdata;
        logic [3:0]               wstrb;
    } clint_access_t;

    // One 12-bit offset, read as msip words or as mtimecmp double words
    typedef union packed {
        struct packed {
            logic [9:0] index;
            logic [1:0] byte_off;
        } as_word;
        struct packed {
            logic [8:0] index;
            logic       high;
            logic [1:0] byte_off;
        } as_dword;
    } clint_offset_u;

endpackage

`default_nettype wire
